//--- rv_exec_top.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ifs.sv
hw/rv_alu.sv
hw/rv_exu.sv
hw/rv_lsu.sv
hw/rv_csr_file.sv
hw/rv_exec_top.sv
bench/tb_rv_exec.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_pkg.sv
      - hw/rv_ifs.sv
      - hw/rv_alu.sv
      - hw/rv_exu.sv
      - hw/rv_lsu.sv
      - hw/rv_csr_file.sv
      - hw/rv_exec_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_rv_exec.sv

//--- bench/tb_rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module tb_rv_exec;
  import rv_pkg::*;

  logic clk, reset, in_valid, in_ready, retire_valid, gpr_wen;
  logic [31:0] pc, src1, src2, imm, alu_a, alu_b, npc, gpr_wdata;
  opcode_e     opcode;
  logic [2:0]  funct;
  logic [4:0]  rd, gpr_waddr;
  alu_op_e     alu_op;
  logic        mem_req_valid, mem_req_ready, mem_req_write, mem_rsp_valid;
  logic [31:0] mem_req_addr, mem_req_wdata, mem_rsp_rdata;
  mem_size_e   mem_req_size;

  logic [31:0] mem [256];
  logic [7:0]  shadow [1024]; // expected memory bytes
  logic [15:0] stim_lfsr, mem_lfsr;
  logic [31:0] ret_npc, ret_wdata;
  logic [4:0]  ret_waddr;

  rv_exec_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(inout logic [15:0] s, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_step(s);
      v = {v[30:0], s[0]}; // one step per bit
    end
  endtask

  function automatic logic [31:0] fill_word(input int i);
    return (i * 32'h0101_0101) ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a, b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_sll:  return a << b[4:0];
      alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      alu_xor:  return a ^ b;
      alu_srl:  return a >> b[4:0];
      alu_sra:  return $signed(a) >>> b[4:0];
      alu_or:   return a | b;
      alu_and:  return a & b;
      default:  return '0;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input logic [2:0] size, input logic [9:0] a);
    logic [31:0] w;
    w = {shadow[{a[9:2], 2'd3}], shadow[{a[9:2], 2'd2}],
         shadow[{a[9:2], 2'd1}], shadow[{a[9:2], 2'd0}]};
    w = w >> (8 * a[1:0]);
    case (size)
      3'b000:  return {{24{w[7]}}, w[7:0]};
      3'b100:  return {24'h0, w[7:0]};
      3'b001:  return {{16{w[15]}}, w[15:0]};
      3'b101:  return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic shadow_store(input logic [2:0] size, input logic [9:0] a, input logic [31:0] d);
    int n;
    n = (size == 3'b000) ? 1 : ((size == 3'b001) ? 2 : 4);
    for (int i = 0; i < n; i++) shadow[a + i] = d[8*i +: 8];
  endtask

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, exp);
    assert (got === exp)
      else stop_on_error($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                   $time, what, got, exp));
  endtask

  task automatic set_instr(input opcode_e op, input logic [2:0] f, input logic [31:0] p,
                           input logic [31:0] a, b, input alu_op_e aop, input logic [31:0] im);
    logic [31:0] r;
    draw(stim_lfsr, 5, r);
    opcode = op;
    funct  = f;
    pc     = p;
    rd     = r[4:0];
    src1   = a;
    src2   = b;
    alu_a  = a;
    alu_b  = b;
    alu_op = aop;
    imm    = im;
  endtask

  // enters and returns on a falling edge
  task automatic send_instr(output int wen_pulses);
    int t;
    in_valid = 1'b1;
    t = 0;
    while (!in_ready) begin
      @(negedge clk);
      t++;
      if (t > 100) stop_on_error("timeout waiting for in_ready");
    end
    @(negedge clk);
    in_valid = 1'b0;
    wen_pulses = 0;
    t = 0;
    while (!retire_valid) begin
      if (gpr_wen) wen_pulses++;
      @(negedge clk);
      t++;
      if (t > 100) stop_on_error("timeout waiting for retire_valid");
    end
    if (gpr_wen) wen_pulses++;
    ret_npc   = npc;
    ret_wdata = gpr_wdata;
    ret_waddr = gpr_waddr;
    @(negedge clk);
    if (gpr_wen) wen_pulses++; // a second pulse would show here
  endtask

  task automatic check_retire(input string what, input int wen_pulses, input int exp_pulses,
                              input logic [31:0] exp_npc, input logic [31:0] exp_wdata);
    check_eq({what, " npc"}, ret_npc, exp_npc);
    check_eq({what, " gpr_wen pulses"}, wen_pulses, exp_pulses);
    if (exp_pulses == 1) begin
      check_eq({what, " gpr_wdata"}, ret_wdata, exp_wdata);
      check_eq({what, " gpr_waddr"}, ret_waddr, rd);
    end
  endtask

  task automatic csr_access(input logic [2:0] f, input logic [11:0] addr,
                            input logic [31:0] operand, input logic [31:0] old);
    alu_op_e aop;
    int      w;
    if (f == 3'b001) aop = alu_pass_b;
    else if (f == 3'b010) aop = alu_set_b;
    else aop = alu_clr_b;
    set_instr(op_sys, f, 32'h200, 32'h0, operand, aop, {20'h0, addr});
    send_instr(w);
    check_retire("csr access", w, 1, 32'h204, old);
  endtask

  // memory model with 1 to 4 cycles of read latency
  initial begin
    logic [31:0] r, rsp_word;
    logic [3:0]  lanes;
    int          rsp_wait;
    mem_lfsr = 16'd24;
    for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_rdata = '0;
    rsp_word = '0;
    rsp_wait = 0;
    forever begin
      @(negedge clk);
      mem_rsp_valid = 1'b0;
      if (rsp_wait > 0) begin
        rsp_wait--;
        if (rsp_wait == 0) begin
          mem_rsp_valid = 1'b1;
          mem_rsp_rdata = rsp_word;
        end
      end
      draw(mem_lfsr, 2, r);
      mem_req_ready = !reset && (r[1:0] != 2'b00); // low about one cycle in four
      if (mem_req_valid && mem_req_ready) begin // taken at the next rising edge
        if (mem_req_write) begin
          case (mem_req_size)
            mem_b, mem_bu: lanes = 4'b0001 << mem_req_addr[1:0];
            mem_h, mem_hu: lanes = 4'b0011 << {mem_req_addr[1], 1'b0};
            default:       lanes = 4'b1111;
          endcase
          for (int j = 0; j < 4; j++)
            if (lanes[j]) mem[mem_req_addr[9:2]][8*j +: 8] = mem_req_wdata[8*j +: 8];
        end else begin
          rsp_word = mem[mem_req_addr[9:2]];
          draw(mem_lfsr, 2, r);
          rsp_wait = r[1:0] + 1;
        end
      end
    end
  end

  initial begin
    logic [31:0] a, b, v, p, u, addr, tvec_v, epc_v;
    logic [2:0]  sz;
    alu_op_e     aop;
    logic        taken;
    int          w, t;
    stim_lfsr = 16'd24;
    reset = 1'b1;
    in_valid = 1'b0;
    set_instr(op_calrr, 3'b000, 32'h0, 32'h0, 32'h0, alu_add, 32'h0);
    for (int i = 0; i < 1024; i++) shadow[i] = 8'(fill_word(i / 4) >> (8 * (i % 4)));
    repeat (16) begin
      @(negedge clk);
      assert (!gpr_wen && !retire_valid && !mem_req_valid)
        else stop_on_error($sformatf("Fail at %0t ns: outputs active while reset is held",
                                     $time));
    end
    reset = 1'b0;
    @(negedge clk);
    assert (in_ready && !gpr_wen && !retire_valid && !mem_req_valid)
      else stop_on_error($sformatf("Fail at %0t ns: wrong output state right after reset",
                                   $time));

    // register and immediate alu ops
    for (int k = 0; k < 10; k++) begin
      repeat (3) begin
        draw(stim_lfsr, 32, a);
        draw(stim_lfsr, 32, b);
        draw(stim_lfsr, 16, v);
        p = {16'h0, v[15:2], 2'b00};
        set_instr(op_calrr, 3'b000, p, a, b, alu_op_e'(k), 32'h0);
        send_instr(w);
        check_retire("calrr", w, 1, p + 4, alu_ref(alu_op_e'(k), a, b));
        b = {{20{b[11]}}, b[11:0]};
        set_instr(op_calri, 3'b000, p, a, b, alu_op_e'(k), b);
        send_instr(w);
        check_retire("calri", w, 1, p + 4, alu_ref(alu_op_e'(k), a, b));
      end
    end
    draw(stim_lfsr, 20, u);
    u = {u[19:0], 12'h0};
    set_instr(op_lui, 3'b000, 32'h100, 32'h0, u, alu_add, u);
    send_instr(w);
    check_retire("lui", w, 1, 32'h104, u);
    set_instr(op_auipc, 3'b000, 32'h180, 32'h180, u, alu_add, u);
    send_instr(w);
    check_retire("auipc", w, 1, 32'h184, 32'h180 + u);

    // branches, jal, jalr
    for (int k = 0; k < 8; k++) begin
      if (k == 2 || k == 3) continue;
      repeat (4) begin
        draw(stim_lfsr, 32, a);
        draw(stim_lfsr, 32, b);
        draw(stim_lfsr, 16, v);
        draw(stim_lfsr, 13, u);
        if (u[12]) b = a; // equal operands now and then
        p = {16'h0, v[15:2], 2'b00};
        u = {{19{u[11]}}, u[11:0], 1'b0};
        case (k)
          0:       taken = (a == b);
          1:       taken = (a != b);
          4:       taken = ($signed(a) < $signed(b));
          5:       taken = ($signed(a) >= $signed(b));
          6:       taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (k < 2) aop = alu_sub;
        else if (k < 6) aop = alu_slt;
        else aop = alu_sltu;
        set_instr(op_branch, 3'(k), p, a, b, aop, u);
        send_instr(w);
        check_retire("branch", w, 0, taken ? p + u : p + 4, 32'h0);
        set_instr(op_jal, 3'b000, p, a, b, alu_add, u);
        send_instr(w);
        check_retire("jal", w, 1, p + u, p + 4);
        u = {{20{v[11]}}, v[11:0]}; // odd offsets too
        set_instr(op_jalr, 3'b000, p, a, b, alu_add, u);
        send_instr(w);
        check_retire("jalr", w, 1, (a + u) & ~32'h1, p + 4);
      end
    end

    // csr read-modify-write
    draw(stim_lfsr, 32, a);
    draw(stim_lfsr, 32, b);
    tvec_v = {a[31:2], 2'b00};
    epc_v = {b[31:2], 2'b00};
    csr_access(3'b001, `CSR_MTVEC, tvec_v, 32'h0);
    csr_access(3'b001, `CSR_MEPC, epc_v, 32'h0);
    csr_access(3'b010, `CSR_MCAUSE, 32'h0, 32'h0);
    draw(stim_lfsr, 32, v);
    csr_access(3'b010, `CSR_MTVEC, v, tvec_v);
    tvec_v = tvec_v | v;
    draw(stim_lfsr, 32, v);
    csr_access(3'b011, `CSR_MEPC, v, epc_v);
    epc_v = epc_v & ~v;
    csr_access(3'b010, `CSR_MTVEC, 32'h0, tvec_v);
    csr_access(3'b010, `CSR_MEPC, 32'h0, epc_v);
    set_instr(op_calrr, 3'b000, 32'h300, 32'h5, 32'h7, alu_add, {20'h0, `CSR_MTVEC});
    send_instr(w);
    check_retire("calrr at csr address", w, 1, 32'h304, 32'hc);
    csr_access(3'b010, `CSR_MTVEC, 32'h0, tvec_v);

    // ecall then mret
    set_instr(op_sys, 3'b000, 32'h840, 32'h0, 32'h0, alu_add, 32'h0);
    send_instr(w);
    check_retire("ecall", w, 0, tvec_v & ~32'h1, 32'h0);
    csr_access(3'b010, `CSR_MEPC, 32'h0, 32'h840);
    csr_access(3'b010, `CSR_MCAUSE, 32'h0, `CAUSE_ECALL);
    set_instr(op_sys, 3'b000, 32'h900, 32'h0, 32'h0, alu_add, 32'h302);
    send_instr(w);
    check_retire("mret", w, 0, 32'h840, 32'h0);

    // stores under random back-pressure
    repeat (24) begin
      draw(stim_lfsr, 2, v);
      sz = (v[1:0] == 2'd0) ? 3'b000 : ((v[1:0] == 2'd1) ? 3'b001 : 3'b010);
      draw(stim_lfsr, 10, addr);
      if (sz[1:0] == 2'b01) addr[0] = 1'b0;
      if (sz[1:0] == 2'b10) addr[1:0] = 2'b00;
      draw(stim_lfsr, 32, b);
      set_instr(op_store, sz, 32'h400, {addr[9:4], 4'h0}, addr[3:0], alu_add, addr[3:0]);
      src2 = b;
      send_instr(w);
      check_retire("store", w, 0, 32'h404, 32'h0);
      shadow_store(sz, addr[9:0], b);
    end
    t = 0;
    while (mem_req_valid) begin
      @(negedge clk);
      t++;
      if (t > 100) stop_on_error("timeout waiting for the store queue to drain");
    end
    for (int i = 0; i < 256; i++)
      check_eq("memory word", mem[i],
               {shadow[4*i+3], shadow[4*i+2], shadow[4*i+1], shadow[4*i]});

    // loads of every size
    repeat (24) begin
      draw(stim_lfsr, 3, v);
      case (v % 5)
        0:       sz = 3'b000;
        1:       sz = 3'b001;
        2:       sz = 3'b010;
        3:       sz = 3'b100;
        default: sz = 3'b101;
      endcase
      draw(stim_lfsr, 10, addr);
      if (sz[1:0] == 2'b01) addr[0] = 1'b0;
      if (sz[1:0] == 2'b10) addr[1:0] = 2'b00;
      set_instr(op_load, sz, 32'h500, {addr[9:4], 4'h0}, addr[3:0], alu_add, addr[3:0]);
      send_instr(w);
      check_retire("load", w, 1, 32'h504, load_ref(sz, addr[9:0]));
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_exec_top (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                in_valid,
  output logic                     in_ready,
  input  wire logic [`RV_XLEN-1:0] pc,
  input  wire rv_pkg::opcode_e     opcode,
  input  wire logic [2:0]          funct,
  input  wire logic [4:0]          rd,
  input  wire logic [`RV_XLEN-1:0] src1,
  input  wire logic [`RV_XLEN-1:0] src2,
  input  wire logic [`RV_XLEN-1:0] imm,
  input  wire logic [`RV_XLEN-1:0] alu_a,
  input  wire logic [`RV_XLEN-1:0] alu_b,
  input  wire rv_pkg::alu_op_e     alu_op,
  output logic [`RV_XLEN-1:0]      npc,
  output logic                     retire_valid,
  output logic                     gpr_wen,
  output logic [4:0]               gpr_waddr,
  output logic [`RV_XLEN-1:0]      gpr_wdata,
  output logic                     mem_req_valid,
  input  wire logic                mem_req_ready,
  output logic                     mem_req_write,
  output logic [`RV_XLEN-1:0]      mem_req_addr,
  output logic [`RV_XLEN-1:0]      mem_req_wdata,
  output rv_pkg::mem_size_e        mem_req_size,
  input  wire logic                mem_rsp_valid,
  input  wire logic [`RV_XLEN-1:0] mem_rsp_rdata
);

  issue_if   issue ();
  mem_req_if lsu_req ();

  logic [11:0]         csr_raddr, csr_waddr1, csr_waddr2;
  logic [`RV_XLEN-1:0] csr_rdata, csr_wdata1, csr_wdata2;
  logic                csr_wen1, csr_wen2;

  assign issue.valid  = in_valid;
  assign in_ready     = issue.ready;
  assign issue.pc     = pc;
  assign issue.opcode = opcode;
  assign issue.funct  = funct;
  assign issue.rd     = rd;
  assign issue.src1   = src1;
  assign issue.src2   = src2;
  assign issue.imm    = imm;
  assign issue.alu_a  = alu_a;
  assign issue.alu_b  = alu_b;
  assign issue.alu_op = alu_op;

  rv_exu exu (
    .clk, .reset, .issue, .mem(lsu_req), .mem_rsp_valid, .mem_rsp_rdata,
    .csr_raddr, .csr_rdata, .csr_wen1, .csr_waddr1, .csr_wdata1,
    .csr_wen2, .csr_waddr2, .csr_wdata2,
    .npc, .retire_valid, .gpr_wen, .gpr_waddr, .gpr_wdata
  );

  rv_lsu lsu (
    .clk, .reset, .in(lsu_req),
    .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr, .mem_req_wdata,
    .mem_req_size
  );

  rv_csr_file csr_file (
    .clk, .reset, .raddr(csr_raddr), .rdata(csr_rdata),
    .wen1(csr_wen1), .waddr1(csr_waddr1), .wdata1(csr_wdata1),
    .wen2(csr_wen2), .waddr2(csr_waddr2), .wdata2(csr_wdata2)
  );

endmodule

`default_nettype wire

//--- hw/rv_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_csr_file (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic [11:0]         raddr,
  output logic [`RV_XLEN-1:0]      rdata,
  input  wire logic                wen1,
  input  wire logic [11:0]         waddr1,
  input  wire logic [`RV_XLEN-1:0] wdata1,
  input  wire logic                wen2,
  input  wire logic [11:0]         waddr2,
  input  wire logic [`RV_XLEN-1:0] wdata2
);

  logic [`RV_XLEN-1:0] mtvec, mepc, mcause;

  always_comb begin
    case (raddr)
      `CSR_MTVEC:  rdata = mtvec;
      `CSR_MEPC:   rdata = mepc;
      `CSR_MCAUSE: rdata = mcause;
      default:     rdata = '0; // unimplemented csr
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
    end else begin
      if (wen1 && waddr1 == `CSR_MTVEC)  mtvec  <= wdata1;
      if (wen1 && waddr1 == `CSR_MEPC)   mepc   <= wdata1;
      if (wen1 && waddr1 == `CSR_MCAUSE) mcause <= wdata1;
      // port 2 last so it takes priority
      if (wen2 && waddr2 == `CSR_MTVEC)  mtvec  <= wdata2;
      if (wen2 && waddr2 == `CSR_MEPC)   mepc   <= wdata2;
      if (wen2 && waddr2 == `CSR_MCAUSE) mcause <= wdata2;
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_lsu (
  input  wire logic           clk,
  input  wire logic           reset,
  mem_req_if.sink             in,
  output logic                mem_req_valid,
  input  wire logic           mem_req_ready,
  output logic                mem_req_write,
  output logic [`RV_XLEN-1:0] mem_req_addr,
  output logic [`RV_XLEN-1:0] mem_req_wdata,
  output rv_pkg::mem_size_e   mem_req_size
);
  import rv_pkg::*;

  localparam int ptr_w = (`LSU_DEPTH > 1) ? $clog2(`LSU_DEPTH) : 1;
  localparam int cnt_w = $clog2(`LSU_DEPTH + 1);

  logic                write_q [`LSU_DEPTH];
  logic [`RV_XLEN-1:0] addr_q  [`LSU_DEPTH];
  logic [`RV_XLEN-1:0] wdata_q [`LSU_DEPTH];
  mem_size_e           size_q  [`LSU_DEPTH];

  logic [ptr_w-1:0] wr_ptr, rd_ptr;
  logic [cnt_w-1:0] count;
  logic [`RV_XLEN-1:0] lane_data;
  logic push, pop;

  assign in.ready      = count < `LSU_DEPTH;
  assign mem_req_valid = count != 0;
  assign push = in.valid && in.ready;
  assign pop  = mem_req_valid && mem_req_ready;

  // move store data onto its byte lanes
  always_comb begin
    case (in.size)
      mem_b, mem_bu: lane_data = {24'b0, in.wdata[7:0]} << {in.addr[1:0], 3'b000};
      mem_h, mem_hu: lane_data = {16'b0, in.wdata[15:0]} << {in.addr[1], 4'b0000};
      default:       lane_data = in.wdata;
    endcase
  end

  assign mem_req_write = write_q[rd_ptr];
  assign mem_req_addr  = addr_q[rd_ptr];
  assign mem_req_wdata = wdata_q[rd_ptr];
  assign mem_req_size  = size_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      write_q[wr_ptr] <= in.write;
      addr_q[wr_ptr]  <= in.addr;
      wdata_q[wr_ptr] <= lane_data;
      size_q[wr_ptr]  <= in.size;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == ptr_w'(`LSU_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == ptr_w'(`LSU_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_exu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_exu (
  input  wire logic                clk,
  input  wire logic                reset,
  issue_if.exu                     issue,
  mem_req_if.src                   mem,
  input  wire logic                mem_rsp_valid,
  input  wire logic [`RV_XLEN-1:0] mem_rsp_rdata,
  output logic [11:0]              csr_raddr,
  input  wire logic [`RV_XLEN-1:0] csr_rdata,
  output logic                     csr_wen1,
  output logic [11:0]              csr_waddr1,
  output logic [`RV_XLEN-1:0]      csr_wdata1,
  output logic                     csr_wen2,
  output logic [11:0]              csr_waddr2,
  output logic [`RV_XLEN-1:0]      csr_wdata2,
  output logic [`RV_XLEN-1:0]      npc,
  output logic                     retire_valid,
  output logic                     gpr_wen,
  output logic [4:0]               gpr_waddr,
  output logic [`RV_XLEN-1:0]      gpr_wdata
);
  import rv_pkg::*;

  typedef enum logic [1:0] {st_idle, st_wait_req, st_wait_rsp} state_e;

  state_e state;
  logic [`RV_XLEN-1:0] alu_a_sel, alu_val, csr_val, link, npc_base, npc_inc, npc_sum;
  logic [`RV_XLEN-1:0] id_gpr_wdata, rsp_lane, load_ext;
  logic id_gpr_wen, br_en, csr_jump, ecall, is_load, is_store, accept;
  logic req_write;
  logic [`RV_XLEN-1:0] req_addr, req_wdata;
  mem_size_e req_size;

  assign is_load  = issue.opcode == op_load;
  assign is_store = issue.opcode == op_store;
  assign csr_jump = (issue.opcode == op_sys) && (issue.funct == 3'b000); // ecall or mret
  assign ecall    = csr_jump && (issue.imm[11:0] == 12'h000);
  assign issue.ready = state == st_idle;
  assign accept = issue.valid && issue.ready;

  // ecall jumps to mtvec, mret to mepc
  assign csr_raddr = ecall ? `CSR_MTVEC : (csr_jump ? `CSR_MEPC : issue.imm[11:0]);

  // forward writes still pending from the previous instruction
  always_comb begin
    if (csr_wen2 && csr_waddr2 == csr_raddr) csr_val = csr_wdata2;
    else if (csr_wen1 && csr_waddr1 == csr_raddr) csr_val = csr_wdata1;
    else csr_val = csr_rdata;
  end

  assign alu_a_sel = (issue.opcode == op_sys) ? csr_val : issue.alu_a;

  rv_alu alu (
    .alu_a (alu_a_sel),
    .alu_b (issue.alu_b),
    .op    (issue.alu_op),
    .val   (alu_val)
  );

  assign link = issue.pc + 32'd4;

  always_comb begin
    case (issue.opcode)
      op_lui, op_auipc, op_jal, op_jalr, op_calri, op_calrr: id_gpr_wen = 1'b1;
      op_sys:  id_gpr_wen = |issue.funct; // csr ops only
      default: id_gpr_wen = 1'b0;         // loads write on the response
    endcase
    case (issue.opcode)
      op_jal, op_jalr: id_gpr_wdata = link;
      op_sys:          id_gpr_wdata = csr_val; // old csr value
      default:         id_gpr_wdata = alu_val;
    endcase
  end

  // branch condition from the alu result
  always_comb begin
    case (br_funct_e'(issue.funct))
      br_beq:          br_en = ~|alu_val;
      br_bne:          br_en = |alu_val;
      br_blt, br_bltu: br_en = alu_val[0];
      br_bge, br_bgeu: br_en = ~alu_val[0];
      default:         br_en = 1'b0;
    endcase
    case (issue.opcode)
      op_jal, op_jalr: npc_inc = issue.imm;
      op_branch:       npc_inc = br_en ? issue.imm : 32'd4;
      op_sys:          npc_inc = csr_jump ? 32'd0 : 32'd4;
      default:         npc_inc = 32'd4;
    endcase
  end

  assign npc_base = (issue.opcode == op_jalr) ? issue.src1 : (csr_jump ? csr_val : issue.pc);
  assign npc_sum  = npc_base + npc_inc;

  // mcause port is fixed to the ecall cause
  assign csr_waddr2 = `CSR_MCAUSE;
  assign csr_wdata2 = `CAUSE_ECALL;

  assign rsp_lane = mem_rsp_rdata >> {req_addr[1:0], 3'b000};
  always_comb begin
    case (req_size)
      mem_b:   load_ext = {{24{rsp_lane[7]}}, rsp_lane[7:0]};
      mem_bu:  load_ext = {24'b0, rsp_lane[7:0]};
      mem_h:   load_ext = {{16{rsp_lane[15]}}, rsp_lane[15:0]};
      mem_hu:  load_ext = {16'b0, rsp_lane[15:0]};
      default: load_ext = mem_rsp_rdata;
    endcase
  end

  assign mem.valid = state == st_wait_req;
  assign mem.write = req_write;
  assign mem.addr  = req_addr;
  assign mem.wdata = req_wdata;
  assign mem.size  = req_size;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= st_idle;
      gpr_wen      <= 1'b0;
      retire_valid <= 1'b0;
      csr_wen1     <= 1'b0;
      csr_wen2     <= 1'b0;
    end else begin
      gpr_wen      <= 1'b0; // single-cycle pulses
      retire_valid <= 1'b0;
      csr_wen1     <= 1'b0;
      csr_wen2     <= 1'b0;
      case (state)
        st_idle: if (issue.valid) begin
          if (is_load || is_store) begin
            state <= st_wait_req;
          end else begin
            gpr_wen      <= id_gpr_wen;
            retire_valid <= 1'b1;
            csr_wen1     <= (issue.opcode == op_sys) && ((|issue.funct) || ecall);
            csr_wen2     <= ecall;
          end
        end
        st_wait_req: if (mem.ready) begin
          if (req_write) begin
            retire_valid <= 1'b1; // store retires once queued
            state        <= st_idle;
          end else begin
            state <= st_wait_rsp;
          end
        end
        st_wait_rsp: if (mem_rsp_valid) begin
          gpr_wen      <= 1'b1;
          retire_valid <= 1'b1;
          state        <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      npc        <= {npc_sum[31:1], 1'b0};
      gpr_waddr  <= issue.rd;
      gpr_wdata  <= id_gpr_wdata;
      csr_waddr1 <= ecall ? `CSR_MEPC : issue.imm[11:0];
      csr_wdata1 <= ecall ? issue.pc : alu_val; // ecall saves pc into mepc
      req_write  <= is_store;
      req_addr   <= alu_val;
      req_wdata  <= issue.src2;
      req_size   <= mem_size_e'(issue.funct);
    end else if (state == st_wait_rsp && mem_rsp_valid) begin
      gpr_wdata <= load_ext;
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_alu (
  input  wire logic [`RV_XLEN-1:0] alu_a,
  input  wire logic [`RV_XLEN-1:0] alu_b,
  input  wire rv_pkg::alu_op_e     op,
  output logic [`RV_XLEN-1:0]      val
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = alu_b[4:0]; // rv32 uses 5 shift bits

  always_comb begin
    case (op)
      alu_add:    val = alu_a + alu_b;
      alu_sub:    val = alu_a - alu_b;
      alu_sll:    val = alu_a << shamt;
      alu_slt:    val = {31'b0, $signed(alu_a) < $signed(alu_b)};
      alu_sltu:   val = {31'b0, alu_a < alu_b};
      alu_xor:    val = alu_a ^ alu_b;
      alu_srl:    val = alu_a >> shamt;
      alu_sra:    val = $unsigned($signed(alu_a) >>> shamt);
      alu_or:     val = alu_a | alu_b;
      alu_and:    val = alu_a & alu_b;
      // csr read-modify-write on the old csr value in alu_a
      alu_pass_b: val = alu_b;
      alu_set_b:  val = alu_a | alu_b;
      alu_clr_b:  val = alu_a & ~alu_b;
      default:    val = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/rv_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

// decoded instruction from the top into the exu
interface issue_if;
  import rv_pkg::*;

  logic               valid;
  logic               ready;
  logic [`RV_XLEN-1:0] pc;
  opcode_e            opcode;
  logic [2:0]         funct;
  logic [4:0]         rd;
  logic [`RV_XLEN-1:0] src1, src2, imm;
  logic [`RV_XLEN-1:0] alu_a, alu_b;
  alu_op_e            alu_op;

  modport exu (input valid, pc, opcode, funct, rd, src1, src2, imm, alu_a, alu_b, alu_op,
               output ready);
  modport src (output valid, pc, opcode, funct, rd, src1, src2, imm, alu_a, alu_b, alu_op,
               input ready);
endinterface

// load/store request, exu to lsu
interface mem_req_if;
  import rv_pkg::*;

  logic               valid;
  logic               ready;
  logic               write;
  logic [`RV_XLEN-1:0] addr;
  logic [`RV_XLEN-1:0] wdata;
  mem_size_e          size;

  modport src  (output valid, write, addr, wdata, size, input ready);
  modport sink (input valid, write, addr, wdata, size, output ready);
endinterface

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // opcode bits 6:2
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_calri  = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_calrr  = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_sys    = 5'b11100
  } opcode_e;

  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_funct_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl,
    alu_sra, alu_or, alu_and,
    alu_pass_b, // csrrw
    alu_set_b,  // csrrs
    alu_clr_b   // csrrc
  } alu_op_e;

  // same encoding as load/store funct3
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_bu = 3'b100,
    mem_hu = 3'b101
  } mem_size_e;

endpackage

`default_nettype wire

//--- hw/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath width
`define RV_XLEN 32

// machine-mode csr addresses
`define CSR_MTVEC  12'h305
`define CSR_MEPC   12'h341
`define CSR_MCAUSE 12'h342

// mcause for ecall from m-mode
`define CAUSE_ECALL 32'd11

// entries in the lsu request fifo
`define LSU_DEPTH 2

`endif
